/* flist.f */
rs_pkg.sv
rs_ptr_ctrl.sv
rs_slot_state.sv
rs_select.sv
rs_entry_array.sv
rs_mul.sv
rs_mul_asserts.sv
tb_rs_mul.sv

/* Bender.yml */
package:
  name: rs_mul

sources:
  - rs_pkg.sv
  - rs_ptr_ctrl.sv
  - rs_slot_state.sv
  - rs_select.sv
  - rs_entry_array.sv
  - rs_mul.sv
  - target: simulation
    files:
      - rs_mul_asserts.sv
      - tb_rs_mul.sv

/* tb_rs_mul.sv */
module tb_rs_mul
    import rs_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_BCAST = 4;

    typedef struct packed {
        logic        dv;
        dispatch_t   d;
        logic [3:0]  bv;   // broadcast valid per port
        logic [31:0] btag; // one tag byte per port, port 0 lowest
        logic        eiv;
        tag_t        erd;
        pc_t         epc;
        logic        efull;
    } row_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   dispatch_valid;
    dispatch_t              dispatch;
    bcast_t [NUM_BCAST-1:0] bcast;
    logic                   issue_valid;
    issue_t                 issue;
    logic                   full;

    row_t rows [$];
    tag_t exp_src1 [256]; // sources by rd, taken from the dispatch stimulus
    tag_t exp_src2 [256];
    int   cur_row;
    int   checks = 0;
    int   errors = 0;
    int   cycles = 0;
    int   cycle_limit = 0;

    rs_mul UUT (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .bcast          (bcast),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .full           (full)
    );

    bind rs_mul rs_mul_asserts u_asserts (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue       (issue),
        .full        (full)
    );

    always #10 clk = ~clk;

    task automatic add_row(
        input logic dv, input pc_t pc, input tag_t rd, input tag_t s1, input tag_t s2,
        input logic [1:0] rdy, input logic [3:0] bv, input logic [31:0] btag,
        input logic eiv, input tag_t erd, input pc_t epc, input logic efull
    );
        row_t r;
        r = '{dv, '{pc, rd, s1, s2, rdy[1], rdy[0]}, bv, btag, eiv, erd, epc, efull};
        rows.push_back(r);
        if (dv) begin
            exp_src1[rd] = s1;
            exp_src2[rd] = s2;
        end
    endtask

    task automatic idle_row(input logic eiv, input tag_t erd, input pc_t epc, input logic efull);
        add_row(0, 0, 0, 0, 0, 2'b00, 4'h0, 0, eiv, erd, epc, efull);
    endtask

    // expected issue shows in the row after the edge that selects it
    task automatic build_table();
        add_row(1, 'h1000, 'h10, 'h01, 'h02, 2'b11, 4'h0, 0, 0, 0, 0, 0); // both ready
        idle_row(1, 'h10, 'h1000, 0);
        add_row(1, 'h2000, 'h20, 'h03, 'h21, 2'b10, 4'h0, 0, 0, 0, 0, 0); // src2 waits
        add_row(1, 'h2004, 'h21, 'h22, 'h04, 2'b01, 4'h0, 0, 0, 0, 0, 0);
        add_row(1, 'h2008, 'h22, 'h05, 'h23, 2'b10, 4'h0, 0, 0, 0, 0, 0);
        add_row(1, 'h200C, 'h23, 'h24, 'h06, 2'b01, 4'h0, 0, 0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, 2'b00, 4'b0001, 'h0000_0021, 0, 0, 0, 0); // port 0
        add_row(0, 0, 0, 0, 0, 2'b00, 4'b0010, 'h0000_2200, 1, 'h20, 'h2000, 0);
        add_row(0, 0, 0, 0, 0, 2'b00, 4'b0100, 'h0023_0000, 1, 'h21, 'h2004, 0);
        add_row(0, 0, 0, 0, 0, 2'b00, 4'b1000, 'h2400_0000, 1, 'h22, 'h2008, 0);
        idle_row(1, 'h23, 'h200C, 0);
        add_row(1, 'h3000, 'h30, 'h31, 'h07, 2'b01, 4'h0, 0, 0, 0, 0, 0); // older, blocked
        add_row(1, 'h3004, 'h32, 'h08, 'h09, 2'b11, 4'h0, 0, 0, 0, 0, 0); // younger, ready
        idle_row(1, 'h32, 'h3004, 0);
        add_row(0, 0, 0, 0, 0, 2'b00, 4'b0001, 'h0000_0031, 0, 0, 0, 0);
        idle_row(1, 'h30, 'h3000, 0);
        add_row(1, 'h4000, 'h40, 'h41, 'h0A, 2'b01, 4'b0100, 'h0041_0000, 0, 0, 0, 0); // bypass
        idle_row(1, 'h40, 'h4000, 0);
        add_row(1, 'h5000, 'h50, 'h5F, 'h0B, 2'b01, 4'h0, 0, 0, 0, 0, 0); // head blocks
        for (int i = 0; i < 8; i++) begin // last one lands outside the window
            add_row(1, 'h5004 + 4*i, 'h52 + i, 'h0C, 'h0D, 2'b11, 4'h0, 0,
                    i != 0, 'h51 + i, 'h5000 + 4*i, 0);
        end
        idle_row(0, 0, 0, 0);
        idle_row(0, 0, 0, 0);
        add_row(0, 0, 0, 0, 0, 2'b00, 4'b1000, 'h5F00_0000, 0, 0, 0, 0);
        idle_row(1, 'h50, 'h5000, 0);
        idle_row(0, 0, 0, 0); // head steps past slot 8
        idle_row(1, 'h59, 'h5020, 0);
        for (int i = 0; i < 16; i++) begin // fills while the head still drains
            add_row(1, 'h6000 + 4*i, 'h60 + i, 'h70 + i, 'h0E, 2'b01, 4'h0, 0,
                    0, 0, 0, i == 15);
        end
        add_row(1, 'h9000, 'h90, 'h0F, 'h0F, 2'b11, 4'h0, 0, 0, 0, 0, 1); // dropped
        add_row(0, 0, 0, 0, 0, 2'b00, 4'b0010, 'h0000_7000, 0, 0, 0, 1);
        idle_row(1, 'h60, 'h6000, 1);
        idle_row(0, 0, 0, 0);
        idle_row(0, 0, 0, 0);
    endtask

    task automatic drive_row(input row_t r);
        dispatch_valid = r.dv;
        dispatch       = r.d;
        for (int b = 0; b < NUM_BCAST; b++) begin
            bcast[b].valid = r.bv[b];
            bcast[b].tag   = r.btag[8*b +: 8];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED row %0d %s: got 0x%h expected 0x%h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_row(input row_t r);
        check_value("issue_valid", issue_valid, r.eiv);
        check_value("full", full, r.efull);
        if (r.eiv) begin
            check_value("issue.rd", issue.rd, r.erd);
            check_value("issue.pc", issue.pc, r.epc);
            check_value("issue.src1", issue.src1, exp_src1[r.erd]);
            check_value("issue.src2", issue.src2, exp_src2[r.erd]);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            cycles++;
            if (cycles >= cycle_limit) begin
                $display("timeout: table not finished after %0d cycles", cycle_limit);
                $display("TB FAILED");
                $finish;
            end
        end
    end

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        bcast          = '0;
        build_table();
        cycle_limit = rows.size() + 20;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            drive_row(rows[i]);
            @(negedge clk); // outputs settled since the rising edge
            cur_row = i;
            check_row(rows[i]);
        end
        drive_row('0);
        errors += UUT.u_asserts.fail_count;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* rs_mul_asserts.sv */
module rs_mul_asserts
    import rs_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   issue_valid,
    input issue_t issue,
    input logic   full
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // rds are unique, so back to back issues differ
    a_rd_repeat: assert property (@(posedge clk) disable iff (reset)
        issue_valid && $past(issue_valid) |-> issue.rd != $past(issue.rd))
        else begin
            fail_count++;
            $error("same rd issued on two consecutive cycles");
        end

    a_full_release: assert property (@(posedge clk) disable iff (reset)
        $fell(full) |-> $past(issue_valid)) // head retires the cycle after its issue
        else begin
            fail_count++;
            $error("full dropped without an issue in the cycle before");
        end

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !issue_valid)
        else begin
            fail_count++;
            $error("issue_valid high during reset");
        end

    a_after_reset: assert property (@(posedge clk)
        reset ##1 !reset |=> !issue_valid)
        else begin
            fail_count++;
            $error("issue_valid high in the first cycle after reset");
        end

endmodule

/* rs_mul.sv */
module rs_mul import rs_pkg::*; #(
    parameter int RS_DEPTH      = 16,
    parameter int SELECT_WINDOW = 8,
    parameter int NUM_BCAST     = 4,
    localparam int IDX_W = $clog2(RS_DEPTH)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   dispatch_valid,
    input  dispatch_t              dispatch,
    input  bcast_t [NUM_BCAST-1:0] bcast,
    output logic                   issue_valid,
    output issue_t                 issue,
    output logic                   full
);

    logic                alloc;
    logic [IDX_W-1:0]    tail_idx;
    logic [IDX_W-1:0]    head_idx;
    logic [RS_DEPTH-1:0] busy;
    logic [RS_DEPTH-1:0] ready;
    logic                issue_fire;
    logic [IDX_W-1:0]    issue_idx;

    rs_ptr_ctrl #(
        .RS_DEPTH (RS_DEPTH)
    ) u_ptr_ctrl (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .busy           (busy),
        .alloc          (alloc),
        .tail_idx       (tail_idx),
        .head_idx       (head_idx),
        .full           (full)
    );

    rs_slot_state #(
        .RS_DEPTH  (RS_DEPTH),
        .NUM_BCAST (NUM_BCAST)
    ) u_slot_state (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .tail_idx   (tail_idx),
        .dispatch   (dispatch),
        .bcast      (bcast),
        .issue_fire (issue_fire),
        .issue_idx  (issue_idx),
        .busy       (busy),
        .ready      (ready)
    );

    rs_select #(
        .RS_DEPTH      (RS_DEPTH),
        .SELECT_WINDOW (SELECT_WINDOW)
    ) u_select (
        .head_idx   (head_idx),
        .ready      (ready),
        .issue_fire (issue_fire),
        .issue_idx  (issue_idx)
    );

    rs_entry_array #(
        .RS_DEPTH (RS_DEPTH)
    ) u_entry_array (
        .clk         (clk),
        .reset       (reset),
        .alloc       (alloc),
        .tail_idx    (tail_idx),
        .dispatch    (dispatch),
        .issue_fire  (issue_fire),
        .issue_idx   (issue_idx),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

endmodule

/* rs_entry_array.sv */
module rs_entry_array import rs_pkg::*; #(
    parameter int RS_DEPTH = 16,
    localparam int IDX_W = $clog2(RS_DEPTH)
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             alloc,
    input  logic [IDX_W-1:0] tail_idx,
    input  dispatch_t        dispatch,
    input  logic             issue_fire,
    input  logic [IDX_W-1:0] issue_idx,
    output logic             issue_valid,
    output issue_t           issue
);

    issue_t entry [RS_DEPTH]; // pc, rd and source tags per slot

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry[tail_idx] <= '{
                pc:   dispatch.pc,
                rd:   dispatch.rd,
                src1: dispatch.src1,
                src2: dispatch.src2
            };
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            issue <= entry[issue_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_fire; // one cycle per selected slot
        end
    end

endmodule

/* rs_select.sv */
module rs_select #(
    parameter int RS_DEPTH      = 16,
    parameter int SELECT_WINDOW = 8,
    localparam int IDX_W = $clog2(RS_DEPTH)
) (
    input  logic [IDX_W-1:0]    head_idx,
    input  logic [RS_DEPTH-1:0] ready,
    output logic                issue_fire,
    output logic [IDX_W-1:0]    issue_idx
);

    // slot index for each window position, wraps past the last slot
    logic [IDX_W-1:0] win_idx [SELECT_WINDOW];

    always_comb begin
        for (int i = 0; i < SELECT_WINDOW; i++) begin
            win_idx[i] = head_idx + IDX_W'(i);
        end
    end

    // oldest ready slot wins
    always_comb begin
        issue_fire = 1'b0;
        issue_idx  = head_idx;
        for (int i = 0; i < SELECT_WINDOW; i++) begin
            if (!issue_fire && ready[win_idx[i]]) begin
                issue_fire = 1'b1;
                issue_idx  = win_idx[i];
            end
        end
    end

endmodule

/* rs_slot_state.sv */
module rs_slot_state import rs_pkg::*; #(
    parameter int RS_DEPTH  = 16,
    parameter int NUM_BCAST = 4,
    localparam int IDX_W = $clog2(RS_DEPTH)
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     alloc,
    input  logic [IDX_W-1:0]         tail_idx,
    input  dispatch_t                dispatch,
    input  bcast_t [NUM_BCAST-1:0]   bcast,
    input  logic                     issue_fire,
    input  logic [IDX_W-1:0]         issue_idx,
    output logic [RS_DEPTH-1:0]      busy,
    output logic [RS_DEPTH-1:0]      ready
);

    tag_t                src1_tag [RS_DEPTH];
    tag_t                src2_tag [RS_DEPTH];
    logic [RS_DEPTH-1:0] src1_rdy;
    logic [RS_DEPTH-1:0] src2_rdy;

    // true when any valid broadcast carries this tag
    function automatic logic tag_hit(input tag_t t, input bcast_t [NUM_BCAST-1:0] bc);
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < NUM_BCAST; b++) begin
            if (bc[b].valid && (bc[b].tag == t)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign ready = busy & src1_rdy & src2_rdy;

    // tags are payload, written on alloc only
    always_ff @(posedge clk) begin
        if (alloc) begin
            src1_tag[tail_idx] <= dispatch.src1;
            src2_tag[tail_idx] <= dispatch.src2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= '0;
            src1_rdy <= '0;
            src2_rdy <= '0;
        end else begin
            // wakeup of stored sources
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (tag_hit(src1_tag[i], bcast)) begin
                    src1_rdy[i] <= 1'b1;
                end
                if (tag_hit(src2_tag[i], bcast)) begin
                    src2_rdy[i] <= 1'b1;
                end
            end
            if (issue_fire) begin
                busy[issue_idx] <= 1'b0;
            end
            // new entry, later assignment wins over the stale wakeup above
            if (alloc) begin
                busy[tail_idx]     <= 1'b1;
                src1_rdy[tail_idx] <= dispatch.src1_ready || tag_hit(dispatch.src1, bcast);
                src2_rdy[tail_idx] <= dispatch.src2_ready || tag_hit(dispatch.src2, bcast);
            end
        end
    end

endmodule

/* rs_ptr_ctrl.sv */
module rs_ptr_ctrl #(
    parameter int RS_DEPTH = 16,
    localparam int IDX_W = $clog2(RS_DEPTH)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  logic [RS_DEPTH-1:0] busy,
    output logic                alloc,
    output logic [IDX_W-1:0]    tail_idx,
    output logic [IDX_W-1:0]    head_idx,
    output logic                full
);

    logic [IDX_W:0] count; // one extra bit to hold RS_DEPTH
    logic           retire;

    assign full   = (count == (IDX_W+1)'(RS_DEPTH));
    assign alloc  = dispatch_valid && !full; // dropped while full
    assign retire = (count != '0) && !busy[head_idx]; // head slot already issued

    always_ff @(posedge clk) begin
        if (reset) begin
            head_idx <= '0;
            tail_idx <= '0;
            count    <= '0;
        end else begin
            if (alloc) begin
                tail_idx <= tail_idx + 1'b1; // wraps, depth is a power of two
            end
            if (retire) begin
                head_idx <= head_idx + 1'b1;
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rs_pkg.sv */
package rs_pkg;

    // physical register tag
    typedef logic [7:0] tag_t;

    // instruction address
    typedef logic [31:0] pc_t;

    // new entry from dispatch
    typedef struct packed {
        pc_t  pc;
        tag_t rd;
        tag_t src1;
        tag_t src2;
        logic src1_ready;
        logic src2_ready;
    } dispatch_t;

    // one result broadcast port
    typedef struct packed {
        logic valid;
        tag_t tag;
    } bcast_t;

    // operation sent to the multiplier
    typedef struct packed {
        pc_t  pc;
        tag_t rd;
        tag_t src1;
        tag_t src2;
    } issue_t;

endpackage
